// File: Bender.yml
package:
  name: udp_axi_bridge

sources:
  - udp_axi_pkg.sv
  - sync_fifo.sv
  - udp_cmd_parser.sv
  - axi_wr_addr_issuer.sv
  - axi_wr_data_issuer.sv
  - axi_wr_resp_reporter.sv
  - udp_axi_bridge.sv
  - target: test
    files:
      - tb_udp_axi_bridge.sv

// File: axi_wr_addr_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_addr_issuer (
    input  wire                                 gmii_rx_clk,
    input  wire                                 rstn,
    input  wire                                 aw_empty,
    input  wire [udp_axi_pkg::aw_entry_w-1:0]   aw_head,
    output logic                                aw_pop,
    output logic [udp_axi_pkg::addr_w-1:0]      awaddr,
    output logic [udp_axi_pkg::len_w-1:0]       awlen,
    output logic [udp_axi_pkg::id_w-1:0]        awid,
    output logic [udp_axi_pkg::burst_w-1:0]     awburst,
    output logic                                awvalid,
    input  wire                                 awready
);

    logic [udp_axi_pkg::aw_entry_w-1:0] aw_q;   // entry on the bus

    assign aw_pop = !aw_empty && !awvalid;

    assign awaddr  = aw_q[udp_axi_pkg::aw_addr_lsb +: udp_axi_pkg::addr_w];
    assign awlen   = aw_q[udp_axi_pkg::aw_len_lsb +: udp_axi_pkg::len_w];
    assign awid    = aw_q[udp_axi_pkg::aw_id_lsb +: udp_axi_pkg::id_w];
    assign awburst = aw_q[udp_axi_pkg::aw_burst_lsb +: udp_axi_pkg::burst_w];

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            awvalid <= 1'b0;
        end else if (aw_pop) begin
            awvalid <= 1'b1;
        end else if (awready) begin
            awvalid <= 1'b0;   // low for a cycle after each handshake
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (aw_pop) begin
            aw_q <= aw_head;
        end
    end

    a_aw_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(awaddr));

endmodule

`default_nettype wire

// File: axi_wr_data_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_data_issuer (
    input  wire                                   gmii_rx_clk,
    input  wire                                   rstn,
    input  wire                                   wd_empty,
    input  wire [udp_axi_pkg::wd_entry_w-1:0]     wd_head,
    output logic                                  wd_pop,
    output logic [udp_axi_pkg::word_w-1:0]        wdata,
    output logic [udp_axi_pkg::word_w/8-1:0]      wstrb,
    output logic                                  wlast,
    output logic                                  wvalid,
    input  wire                                   wready
);

    logic [udp_axi_pkg::len_w:0] beat_cnt;   // beats of the current burst

    assign wvalid = !wd_empty;
    assign wdata  = wd_head[udp_axi_pkg::word_w-1:0];
    assign wlast  = wd_head[udp_axi_pkg::word_w];
    assign wstrb  = '1;                      // full words only
    assign wd_pop = wvalid && wready;

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (wd_pop) begin
            beat_cnt <= wlast ? '0 : beat_cnt + 1'b1;
        end
    end

    // a burst longer than the counter would break the framing
    a_burst_fits: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        wd_pop && !wlast |=> beat_cnt != '0);

endmodule

`default_nettype wire

// File: axi_wr_resp_reporter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_resp_reporter #(
    parameter int br_depth = 16
) (
    input  wire                              gmii_rx_clk,
    input  wire                              rstn,
    input  wire [udp_axi_pkg::id_w-1:0]      bid,
    input  wire [udp_axi_pkg::resp_w-1:0]    bresp,
    input  wire                              bvalid,
    output logic                             bready,
    output logic                             udp_tx_start,
    output logic [15:0]                      udp_tx_byte_num,
    output logic [udp_axi_pkg::word_w-1:0]   udp_tx_data,
    input  wire                              udp_tx_req,
    input  wire                              udp_tx_done
);

    localparam logic [1:0] st_idle      = 2'd0;
    localparam logic [1:0] st_wait_req  = 2'd1;
    localparam logic [1:0] st_wait_done = 2'd2;

    logic [1:0]                           state;
    logic                                 ready_q;   // set once out of reset
    logic                                 br_full;
    logic                                 br_empty;
    logic                                 br_pop;
    logic [udp_axi_pkg::br_entry_w-1:0]   br_head;

    assign bready          = ready_q && !br_full;
    assign br_pop          = (state == st_wait_req) && udp_tx_req;
    assign udp_tx_byte_num = udp_axi_pkg::report_bytes;

    sync_fifo #(
        .depth (br_depth),
        .width (udp_axi_pkg::br_entry_w)
    ) br_fifo (
        .clk     (gmii_rx_clk),
        .rstn    (rstn),
        .wr_en   (bvalid && bready),
        .wr_data ({bid, bresp}),
        .rd_en   (br_pop),
        .rd_data (br_head),
        .full    (br_full),
        .empty   (br_empty)
    );

    always_comb begin
        udp_tx_data = '0;
        udp_tx_data[udp_axi_pkg::rpt_tag_lsb +: 8] = udp_axi_pkg::marker_data;
        udp_tx_data[udp_axi_pkg::rpt_id_lsb +: udp_axi_pkg::id_w] =
            br_head[udp_axi_pkg::br_id_lsb +: udp_axi_pkg::id_w];
        udp_tx_data[udp_axi_pkg::rpt_resp_lsb +: udp_axi_pkg::resp_w] =
            br_head[udp_axi_pkg::br_resp_lsb +: udp_axi_pkg::resp_w];
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state        <= st_idle;
            ready_q      <= 1'b0;
            udp_tx_start <= 1'b0;
        end else begin
            ready_q      <= 1'b1;
            udp_tx_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (!br_empty) begin
                        udp_tx_start <= 1'b1;   // one-cycle pulse
                        state        <= st_wait_req;
                    end
                end
                st_wait_req: begin
                    if (udp_tx_req) begin
                        state <= st_wait_done;
                    end
                end
                st_wait_done: begin
                    if (udp_tx_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int depth = 16,
    parameter int width = 32
) (
    input  wire              clk,
    input  wire              rstn,
    input  wire              wr_en,
    input  wire [width-1:0]  wr_data,
    input  wire              rd_en,
    output logic [width-1:0] rd_data,
    output logic             full,
    output logic             empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(depth);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    assign full    = (count == full_cnt);
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];   // head shown ahead of the read

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn) !(wr_en && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn) !(rd_en && empty));

endmodule

`default_nettype wire

// File: tb_udp_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_udp_axi_bridge;

    localparam int n_rows   = 8;
    localparam int n_burst  = 24;   // responses sent against a slow tx side
    localparam int br_depth = 16;

    localparam logic [1:0] k_cmd   = 2'd0;
    localparam logic [1:0] k_data  = 2'd1;
    localparam logic [1:0] k_other = 2'd2;

    logic        gmii_rx_clk;
    logic        rstn;
    logic        udp_rx_en;
    logic        udp_rx_done;
    logic [31:0] udp_rx_data;
    logic [31:0] awaddr;
    logic [7:0]  awlen;
    logic [1:0]  awid;
    logic [1:0]  awburst;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bid;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic        udp_tx_start;
    logic [15:0] udp_tx_byte_num;
    logic [31:0] udp_tx_data;
    logic        udp_tx_req;
    logic        udp_tx_done;

    logic [1:0]   row_kind [n_rows];
    logic [255:0] row_words [n_rows];   // word 0 in the low bits
    int           row_len [n_rows];

    logic [43:0] exp_aw [$];      // {burst, id, len, addr}
    logic [32:0] exp_w [$];       // {last, data}
    logic [31:0] exp_rpt [$];
    logic [3:0]  b_pending [$];   // {id, resp} still to be sent on B

    int          cycles;
    int          limit;
    int          post_rst;
    int          br_occ;          // modeled depth of the response queue
    bit          saw_full;
    bit          tx_busy;
    bit          b_burst;
    bit          slow_tx;
    int unsigned seed_ret;

    udp_axi_bridge #(.aw_depth(16), .wd_depth(256), .br_depth(br_depth)) DUT (.*);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("[ERROR] time %0t %s expected 0x%0h actual 0x%0h",
                               $time, name, expected, actual));
        end
    endtask

    function automatic logic [31:0] report_word(input logic [1:0] id, input logic [1:0] resp);
        return {8'hFF, 6'd0, id, 6'd0, resp, 8'd0};
    endfunction

    task automatic set_row(input int r, input logic [1:0] kind, input int len,
                           input logic [255:0] words);
        row_kind[r]  = kind;
        row_len[r]   = len;
        row_words[r] = words;
    endtask

    task automatic load_table();
        set_row(0, k_cmd, 3, {32'h1000_0000, 32'h0051_0300, 32'h0000_0000});
        // write, read, write
        set_row(1, k_cmd, 7, {32'h4000_0080, 32'h0071_0000, 32'h3000_0000, 32'h0050_0700,
                              32'h2000_0040, 32'h00A1_0F00, 32'h0000_0000});
        // foreign marker pair, then a write
        set_row(2, k_cmd, 5, {32'h5000_0100, 32'h0001_0100, 32'h3000_1000, 32'h1251_0100,
                              32'h0000_0000});
        set_row(3, k_data, 5, {32'hDEAD_0004, 32'hDEAD_0003, 32'hDEAD_0002, 32'hDEAD_0001,
                               32'hFF00_0000});
        set_row(4, k_other, 3, {32'h6000_0000, 32'h0051_0300, 32'h5500_0000});
        set_row(5, k_data, 8, {32'hA5A5_0007, 32'hA5A5_0006, 32'hA5A5_0005, 32'hA5A5_0004,
                               32'hA5A5_0003, 32'hA5A5_0002, 32'hA5A5_0001, 32'hFF12_3456});
        set_row(6, k_data, 2, {32'h1234_5678, 32'hFF00_0000});
        set_row(7, k_cmd, 3, {32'h7000_0200, 32'h00E1_0700, 32'h0000_0000});
    endtask

    // expected bus traffic of one row
    task automatic expect_row(input int r);
        logic [31:0] hdr;
        logic [31:0] addr;
        logic        last;
        if (row_kind[r] == k_cmd) begin
            for (int i = 1; i + 1 < row_len[r]; i += 2) begin
                hdr  = row_words[r][i*32 +: 32];
                addr = row_words[r][(i+1)*32 +: 32];
                if (hdr[31:24] == 8'h00 && hdr[16]) begin   // write pairs only
                    exp_aw.push_back({hdr[23:22], hdr[21:20], hdr[15:8], addr});
                end
            end
        end else if (row_kind[r] == k_data) begin
            for (int i = 1; i < row_len[r]; i++) begin
                last = (i == row_len[r] - 1);
                exp_w.push_back({last, row_words[r][i*32 +: 32]});
            end
        end
    endtask

    task automatic send_row(input int r);
        for (int i = 0; i < row_len[r]; i++) begin
            @(negedge gmii_rx_clk);
            udp_rx_en   = 1'b1;
            udp_rx_data = row_words[r][i*32 +: 32];
            udp_rx_done = (i == row_len[r] - 1);
        end
        @(negedge gmii_rx_clk);
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
        repeat (2) @(negedge gmii_rx_clk);   // gap between packets
    endtask

    // returns once the buses have been idle for n cycles in a row
    task automatic wait_quiet(input int n);
        int quiet;
        quiet = 0;
        while (quiet < n) begin
            @(negedge gmii_rx_clk);
            if (awvalid || wvalid || bvalid || udp_tx_start || tx_busy
                || b_pending.size() != 0) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    initial begin
        gmii_rx_clk = 1'b0;
        forever #50 gmii_rx_clk = ~gmii_rx_clk;
    end

    initial begin
        int total;
        seed_ret    = $urandom(32'h0e595800);
        rstn        = 1'b0;
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
        udp_rx_data = '0;
        awready     = 1'b0;
        wready      = 1'b0;
        bid         = '0;
        bresp       = '0;
        bvalid      = 1'b0;
        udp_tx_req  = 1'b0;
        udp_tx_done = 1'b0;
        cycles      = 0;
        post_rst    = 0;
        br_occ      = 0;
        load_table();
        total = 0;
        for (int r = 0; r < n_rows; r++) begin
            total += row_len[r];
        end
        limit = total * 20 + 200;
        repeat (10) @(negedge gmii_rx_clk);
        rstn = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            expect_row(r);
            send_row(r);
        end
        wait_quiet(20);
        slow_tx = 1'b1;   // tx side now holds each frame long enough to fill the queue
        b_burst = 1'b1;
        for (int i = 0; i < n_burst; i++) begin
            b_pending.push_back($urandom_range(15, 0));
        end
        wait_quiet(20);
        if (exp_aw.size() != 0 || exp_w.size() != 0 || exp_rpt.size() != 0) begin
            fail_run($sformatf("expected entries left over: %0d aw, %0d w, %0d reports",
                               exp_aw.size(), exp_w.size(), exp_rpt.size()));
        end else if (!saw_full) begin
            fail_run("bready never dropped during the response burst");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

    always @(posedge gmii_rx_clk) begin
        if (rstn) begin
            cycles++;
            if (cycles >= limit) begin
                fail_run($sformatf("timeout after %0d cycles, traffic did not complete", cycles));
            end
        end
    end

    initial begin : ready_driver
        forever begin
            @(negedge gmii_rx_clk);
            awready = ($urandom_range(3, 0) != 0);   // stalls about a quarter of cycles
            wready  = ($urandom_range(3, 0) != 0);
        end
    end

    initial begin : b_driver
        forever begin
            @(negedge gmii_rx_clk);
            if (b_pending.size() != 0 && (b_burst || $urandom_range(2, 0) == 0)) begin
                {bid, bresp} = b_pending.pop_front();
                bvalid = 1'b1;
                @(posedge gmii_rx_clk);
                while (!bready) @(posedge gmii_rx_clk);
            end else begin
                bvalid = 1'b0;
            end
        end
    end

    always @(posedge gmii_rx_clk) begin
        logic [43:0] e;
        logic [1:0]  resp;
        if (rstn && awvalid && awready) begin
            if (exp_aw.size() == 0) begin
                fail_run("AW handshake with no write header pending");
            end else begin
                e = exp_aw.pop_front();
                compare("awaddr", e[31:0], awaddr);
                compare("awlen", e[39:32], awlen);
                compare("awid", e[41:40], awid);
                compare("awburst", e[43:42], awburst);
                resp = $urandom_range(3, 0);
                b_pending.push_back({awid, resp});   // slave answers every write
            end
        end
    end

    always @(posedge gmii_rx_clk) begin
        logic [32:0] e;
        if (rstn && wvalid && wready) begin
            if (exp_w.size() == 0) begin
                fail_run("W beat with no payload word pending");
            end else begin
                e = exp_w.pop_front();
                compare("wdata", e[31:0], wdata);
                compare("wlast", e[32], wlast);
                compare("wstrb", 4'hF, wstrb);
            end
        end
    end

    always @(posedge gmii_rx_clk) begin
        if (rstn) begin
            post_rst++;
            // bready comes up one cycle after reset
            compare("bready", post_rst > 1 && br_occ != br_depth, bready);
            if (post_rst > 1 && !bready) begin
                saw_full = 1'b1;
            end
            if (bvalid && bready) begin
                exp_rpt.push_back(report_word(bid, bresp));
                br_occ++;
            end
            if (udp_tx_req) begin
                br_occ--;
            end
        end
    end

    always @(posedge gmii_rx_clk) begin
        if (rstn && udp_tx_start) begin
            if (tx_busy) begin
                fail_run("udp_tx_start pulsed before the previous frame saw udp_tx_done");
            end else begin
                tx_busy = 1'b1;
            end
        end
        if (udp_tx_done) begin
            tx_busy = 1'b0;
        end
    end

    initial begin : tx_model
        forever begin
            @(posedge gmii_rx_clk);
            if (rstn && udp_tx_start) begin
                compare("udp_tx_byte_num", 16'd4, udp_tx_byte_num);
                repeat ($urandom_range(3, 1)) @(negedge gmii_rx_clk);
                udp_tx_req = 1'b1;
                @(posedge gmii_rx_clk);
                if (exp_rpt.size() == 0) begin
                    fail_run("tx frame sent with no write response behind it");
                end else begin
                    compare("udp_tx_data", exp_rpt.pop_front(), udp_tx_data);
                end
                @(negedge gmii_rx_clk);
                udp_tx_req = 1'b0;
                repeat (slow_tx ? 6 : $urandom_range(3, 0)) @(negedge gmii_rx_clk);
                udp_tx_done = 1'b1;
                @(negedge gmii_rx_clk);
                udp_tx_done = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: udp_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module udp_axi_bridge #(
    parameter int aw_depth = 16,
    parameter int wd_depth = 256,
    parameter int br_depth = 16
) (
    input  wire                              gmii_rx_clk,
    input  wire                              rstn,
    input  wire                              udp_rx_en,
    input  wire                              udp_rx_done,
    input  wire [udp_axi_pkg::word_w-1:0]    udp_rx_data,
    output logic [udp_axi_pkg::addr_w-1:0]   awaddr,
    output logic [udp_axi_pkg::len_w-1:0]    awlen,
    output logic [udp_axi_pkg::id_w-1:0]     awid,
    output logic [udp_axi_pkg::burst_w-1:0]  awburst,
    output logic                             awvalid,
    input  wire                              awready,
    output logic [udp_axi_pkg::word_w-1:0]   wdata,
    output logic [udp_axi_pkg::word_w/8-1:0] wstrb,
    output logic                             wlast,
    output logic                             wvalid,
    input  wire                              wready,
    input  wire [udp_axi_pkg::id_w-1:0]      bid,
    input  wire [udp_axi_pkg::resp_w-1:0]    bresp,
    input  wire                              bvalid,
    output logic                             bready,
    output logic                             udp_tx_start,
    output logic [15:0]                      udp_tx_byte_num,
    output logic [udp_axi_pkg::word_w-1:0]   udp_tx_data,
    input  wire                              udp_tx_req,
    input  wire                              udp_tx_done
);

    logic                                 aw_push, aw_pop, aw_empty;
    logic [udp_axi_pkg::aw_entry_w-1:0]   aw_entry, aw_head;
    logic                                 wd_push, wd_pop, wd_empty;
    logic [udp_axi_pkg::wd_entry_w-1:0]   wd_entry, wd_head;

    udp_cmd_parser u_parser (
        .gmii_rx_clk, .rstn, .udp_rx_en, .udp_rx_done, .udp_rx_data,
        .aw_push, .aw_entry, .wd_push, .wd_entry
    );

    // no back-pressure on the rx side
    sync_fifo #(.depth(aw_depth), .width(udp_axi_pkg::aw_entry_w)) aw_fifo (
        .clk (gmii_rx_clk), .rstn, .wr_en (aw_push), .wr_data (aw_entry),
        .rd_en (aw_pop), .rd_data (aw_head), .full (), .empty (aw_empty)
    );

    sync_fifo #(.depth(wd_depth), .width(udp_axi_pkg::wd_entry_w)) wd_fifo (
        .clk (gmii_rx_clk), .rstn, .wr_en (wd_push), .wr_data (wd_entry),
        .rd_en (wd_pop), .rd_data (wd_head), .full (), .empty (wd_empty)
    );

    axi_wr_addr_issuer u_aw_issuer (
        .gmii_rx_clk, .rstn, .aw_empty, .aw_head, .aw_pop,
        .awaddr, .awlen, .awid, .awburst, .awvalid, .awready
    );

    axi_wr_data_issuer u_w_issuer (
        .gmii_rx_clk, .rstn, .wd_empty, .wd_head, .wd_pop,
        .wdata, .wstrb, .wlast, .wvalid, .wready
    );

    axi_wr_resp_reporter #(.br_depth(br_depth)) u_reporter (
        .gmii_rx_clk, .rstn, .bid, .bresp, .bvalid, .bready,
        .udp_tx_start, .udp_tx_byte_num, .udp_tx_data, .udp_tx_req, .udp_tx_done
    );

endmodule

`default_nettype wire

// File: udp_axi_pkg.sv
`default_nettype none

package udp_axi_pkg;

    localparam int word_w  = 32;          // udp word and axi data
    localparam int addr_w  = 32;
    localparam int len_w   = 8;
    localparam int id_w    = 2;
    localparam int burst_w = 2;
    localparam int resp_w  = 2;

    localparam logic [7:0] marker_cmd  = 8'h00;   // address packet
    localparam logic [7:0] marker_data = 8'hFF;   // data packet, report tag

    // header word 0 fields, header word 1 is the address
    localparam int hdr_marker_lsb = 24;
    localparam int hdr_burst_lsb  = 22;
    localparam int hdr_id_lsb     = 20;
    localparam int hdr_wr_bit     = 16;
    localparam int hdr_len_lsb    = 8;

    // write-address entry, {burst, id, len, addr}
    localparam int aw_addr_lsb  = 0;
    localparam int aw_len_lsb   = aw_addr_lsb + addr_w;
    localparam int aw_id_lsb    = aw_len_lsb + len_w;
    localparam int aw_burst_lsb = aw_id_lsb + id_w;
    localparam int aw_entry_w   = aw_burst_lsb + burst_w;   // 44

    localparam int wd_entry_w = word_w + 1;   // {last, data}

    // response entry, {id, resp}
    localparam int br_resp_lsb = 0;
    localparam int br_id_lsb   = resp_w;
    localparam int br_entry_w  = id_w + resp_w;

    // report frame, a single word
    localparam logic [15:0] report_bytes = 16'd4;
    localparam int rpt_tag_lsb  = 24;
    localparam int rpt_id_lsb   = 16;
    localparam int rpt_resp_lsb = 8;

endpackage

`default_nettype wire

// File: udp_cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module udp_cmd_parser (
    input  wire                                    gmii_rx_clk,
    input  wire                                    rstn,
    input  wire                                    udp_rx_en,
    input  wire                                    udp_rx_done,
    input  wire [udp_axi_pkg::word_w-1:0]          udp_rx_data,
    output logic                                   aw_push,
    output logic [udp_axi_pkg::aw_entry_w-1:0]     aw_entry,
    output logic                                   wd_push,
    output logic [udp_axi_pkg::wd_entry_w-1:0]     wd_entry
);

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_header = 2'd1;
    localparam logic [1:0] st_data   = 2'd2;
    localparam logic [1:0] st_skip   = 2'd3;

    logic [1:0]                       state;
    logic                             pair_cnt;    // 0 on word 0 of a pair
    logic [udp_axi_pkg::word_w-1:0]   hdr0;
    logic [7:0]                       rx_marker;
    logic                             hdr_is_wr;

    assign rx_marker = udp_rx_data[udp_axi_pkg::hdr_marker_lsb +: 8];
    assign hdr_is_wr = (hdr0[udp_axi_pkg::hdr_marker_lsb +: 8] == udp_axi_pkg::marker_cmd)
                       && hdr0[udp_axi_pkg::hdr_wr_bit];

    // payload words go straight to the data fifo
    assign wd_push  = (state == st_data) && udp_rx_en;
    assign wd_entry = {udp_rx_done, udp_rx_data};

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state    <= st_idle;
            pair_cnt <= 1'b0;
            aw_push  <= 1'b0;
        end else begin
            aw_push <= 1'b0;
            if (udp_rx_en) begin
                case (state)
                    st_idle: begin
                        pair_cnt <= 1'b0;
                        if (!udp_rx_done) begin   // single-word packet carries nothing
                            if (rx_marker == udp_axi_pkg::marker_cmd) begin
                                state <= st_header;
                            end else if (rx_marker == udp_axi_pkg::marker_data) begin
                                state <= st_data;
                            end else begin
                                state <= st_skip;
                            end
                        end
                    end
                    st_header: begin
                        pair_cnt <= ~pair_cnt;
                        if (pair_cnt && hdr_is_wr) begin
                            aw_push <= 1'b1;   // read and foreign pairs dropped
                        end
                        if (udp_rx_done) begin
                            state <= st_idle;
                        end
                    end
                    default: begin
                        if (udp_rx_done) begin
                            state <= st_idle;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (udp_rx_en && state == st_header) begin
            if (!pair_cnt) begin
                hdr0 <= udp_rx_data;
            end else begin
                aw_entry <= {hdr0[udp_axi_pkg::hdr_burst_lsb +: udp_axi_pkg::burst_w],
                             hdr0[udp_axi_pkg::hdr_id_lsb +: udp_axi_pkg::id_w],
                             hdr0[udp_axi_pkg::hdr_len_lsb +: udp_axi_pkg::len_w],
                             udp_rx_data};   // word 1 is the address
            end
        end
    end

    a_done_with_en: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        udp_rx_done |-> udp_rx_en);

endmodule

`default_nettype wire

// File: verilog.f
udp_axi_pkg.sv
sync_fifo.sv
udp_cmd_parser.sv
axi_wr_addr_issuer.sv
axi_wr_data_issuer.sv
axi_wr_resp_reporter.sv
udp_axi_bridge.sv
tb_udp_axi_bridge.sv
